// ==== source/vmode_consts.svh ====
`ifndef VMODE_CONSTS_SVH
`define VMODE_CONSTS_SVH

// ==================================================
// address map.
// ==================================================

`define VMODE_PAL_BASE     32'h0080_0000
`define VMODE_REG_BASE     32'h0081_0000

// register offsets within the register region.
`define VMODE_REG_VRAM_OFS 32'h0000_0000
`define VMODE_REG_CPU_OFS  32'h0000_0004

// ==================================================
// geometry and sizes.
// ==================================================

`define VMODE_PITCH        320
`define VMODE_VRAM_WORDS   8192
`define VMODE_PAL_SIZE     256

`endif

// ==== source/vmode_pkg.sv ====
`default_nettype none

package vmode_pkg;

	// cpu and vram bus.
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	// red in the high byte.
	typedef logic [23:0] rgb_t;

	typedef logic [7:0] pal_index_t;
	typedef logic [8:0] coord_t;

	// video fetcher.
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_WAIT,
		FETCH_LOOK,
		FETCH_SEND
	} fetch_state_t;

endpackage

`default_nettype wire

// ==== source/palette_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vmode_consts.svh"

module palette_ram (
	input  wire                    i_clock,

	input  wire                    i_wr_en,
	input  wire vmode_pkg::pal_index_t i_wr_index,
	input  wire vmode_pkg::rgb_t   i_wr_rgb,

	input  wire vmode_pkg::pal_index_t i_rd_index,
	output vmode_pkg::rgb_t        o_rd_rgb
);

	import vmode_pkg::*;

	rgb_t mem [`VMODE_PAL_SIZE];

	// cpu write port.
	always_ff @(posedge i_clock) begin
		if (i_wr_en)
			mem[i_wr_index] <= i_wr_rgb;
	end

	// video read port, one cycle of latency.
	always_ff @(posedge i_clock) begin
		o_rd_rgb <= mem[i_rd_index];
	end

endmodule

`default_nettype wire

// ==== source/vram_dual.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vmode_consts.svh"

module vram_dual (
	input  wire                  i_clock,
	input  wire                  i_rst_n,

	input  wire                  i_pa_request,
	input  wire                  i_pa_rw,
	input  wire vmode_pkg::addr_t i_pa_address,
	input  wire vmode_pkg::word_t i_pa_wdata,
	output vmode_pkg::word_t     o_pa_rdata,
	output logic                 o_pa_ready,

	input  wire                  i_pb_request,
	input  wire                  i_pb_rw,
	input  wire vmode_pkg::addr_t i_pb_address,
	input  wire vmode_pkg::word_t i_pb_wdata,
	output vmode_pkg::word_t     o_pb_rdata,
	output logic                 o_pb_ready
);

	import vmode_pkg::*;

	localparam int WORD_BITS = $clog2(`VMODE_VRAM_WORDS);

	word_t mem [`VMODE_VRAM_WORDS];

	logic [1:0] port_req;
	logic [1:0] port_rw;
	logic [1:0] port_take;
	logic [1:0] port_served;
	logic [1:0] port_ready;
	addr_t port_addr [2];
	word_t port_wdata [2];
	word_t port_rdata [2];
	logic [WORD_BITS-1:0] port_index [2];

	assign port_req = {i_pb_request, i_pa_request};
	assign port_rw = {i_pb_rw, i_pa_rw};
	assign port_addr[0] = i_pa_address;
	assign port_addr[1] = i_pb_address;
	assign port_wdata[0] = i_pa_wdata;
	assign port_wdata[1] = i_pb_wdata;

	assign o_pa_rdata = port_rdata[0];
	assign o_pb_rdata = port_rdata[1];
	assign o_pa_ready = port_ready[0];
	assign o_pb_ready = port_ready[1];

	for (genvar p = 0; p < 2; p++) begin : g_port
		// a held request is served once.
		assign port_take[p] = port_req[p] && !port_served[p];
		assign port_index[p] = port_addr[p][WORD_BITS+1:2];

		// the requester drops its request only after the ready pulse.
		a_request_held_until_ready: assert property (@(posedge i_clock)
			disable iff (!i_rst_n)
			$fell(port_req[p]) |-> $past(port_ready[p]));
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			port_served <= '0;
			port_ready <= '0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				port_ready[p] <= port_take[p];
				if (!port_req[p])
					port_served[p] <= 1'b0;
				else if (port_take[p])
					port_served[p] <= 1'b1;
			end
		end
	end

	// port b wins a write to the same word.
	always_ff @(posedge i_clock) begin
		for (int p = 0; p < 2; p++) begin
			if (port_take[p]) begin
				if (port_rw[p])
					mem[port_index[p]] <= port_wdata[p];
				port_rdata[p] <= mem[port_index[p]];
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/chunky_mode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vmode_consts.svh"

module chunky_mode (
	input  wire                   i_clock,
	input  wire                   i_rst_n,

	input  wire                   i_cpu_request,
	input  wire                   i_cpu_rw,
	input  wire vmode_pkg::addr_t i_cpu_address,
	input  wire vmode_pkg::word_t i_cpu_wdata,
	output vmode_pkg::word_t      o_cpu_rdata,
	output logic                  o_cpu_ready,

	input  wire                   i_video_request,
	input  wire vmode_pkg::coord_t i_video_pos_x,
	input  wire vmode_pkg::coord_t i_video_pos_y,
	output vmode_pkg::rgb_t       o_video_rgb,
	output logic                  o_video_valid,

	output logic                  o_vram_pa_request,
	output logic                  o_vram_pa_rw,
	output vmode_pkg::addr_t      o_vram_pa_address,
	output vmode_pkg::word_t      o_vram_pa_wdata,
	input  wire vmode_pkg::word_t i_vram_pa_rdata,
	input  wire                   i_vram_pa_ready,

	output logic                  o_vram_pb_request,
	output logic                  o_vram_pb_rw,
	output vmode_pkg::addr_t      o_vram_pb_address,
	output vmode_pkg::word_t      o_vram_pb_wdata,
	input  wire vmode_pkg::word_t i_vram_pb_rdata,
	input  wire                   i_vram_pb_ready
);

	import vmode_pkg::*;

	addr_t cpu_offset;
	addr_t vram_offset;
	addr_t pal_offset;
	addr_t reg_offset;
	logic cpu_served;
	logic cpu_start;
	logic cpu_in_vram;
	logic cpu_in_pal;
	logic vram_done;
	logic pal_wr_en;

	fetch_state_t fetch_state;
	logic [2:0] look_cnt;
	word_t quad_word;
	rgb_t colour [4];
	rgb_t pal_rd_rgb;
	pal_index_t pal_rd_index;
	addr_t fetch_address;
	logic fetch_start;
	logic pixel_hit;
	logic word_taken;
	logic look_store;

	palette_ram u_palette (
		.i_clock    (i_clock),
		.i_wr_en    (pal_wr_en),
		.i_wr_index (pal_offset[9:2]),
		.i_wr_rgb   (i_cpu_wdata[23:0]),
		.i_rd_index (pal_rd_index),
		.o_rd_rgb   (pal_rd_rgb)
	);

	// ==================================================
	// cpu side.
	// ==================================================

	assign cpu_in_vram = i_cpu_address < `VMODE_PAL_BASE;
	assign cpu_in_pal = !cpu_in_vram && (i_cpu_address < `VMODE_REG_BASE);
	assign pal_offset = i_cpu_address - `VMODE_PAL_BASE;
	assign reg_offset = i_cpu_address - `VMODE_REG_BASE;

	// new access only once the last one was answered and dropped.
	assign cpu_start = i_cpu_request && !cpu_served && !o_vram_pa_request;
	assign vram_done = o_vram_pa_request && i_vram_pa_ready;
	assign pal_wr_en = cpu_start && cpu_in_pal && i_cpu_rw;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_cpu_ready <= 1'b0;
			o_vram_pa_request <= 1'b0;
			cpu_served <= 1'b0;
			cpu_offset <= '0;
			vram_offset <= '0;
		end else begin
			o_cpu_ready <= 1'b0;
			if (!i_cpu_request)
				cpu_served <= 1'b0;
			if (vram_done) begin
				o_vram_pa_request <= 1'b0;
				o_cpu_ready <= 1'b1;
				cpu_served <= 1'b1;
			end else if (cpu_start) begin
				if (cpu_in_vram) begin
					o_vram_pa_request <= 1'b1;
				end else begin
					o_cpu_ready <= 1'b1;
					cpu_served <= 1'b1;
					if (!cpu_in_pal && i_cpu_rw) begin
						if (reg_offset == `VMODE_REG_VRAM_OFS)
							vram_offset <= i_cpu_wdata;
						else if (reg_offset == `VMODE_REG_CPU_OFS)
							cpu_offset <= i_cpu_wdata;
					end
				end
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (cpu_start && cpu_in_vram) begin
			o_vram_pa_rw <= i_cpu_rw;
			o_vram_pa_address <= cpu_offset + i_cpu_address;
			o_vram_pa_wdata <= i_cpu_wdata;
		end
		// palette and registers read as zero.
		if (vram_done)
			o_cpu_rdata <= i_vram_pa_rdata;
		else if (cpu_start && !cpu_in_vram)
			o_cpu_rdata <= '0;
	end

	// ==================================================
	// video side.
	// ==================================================

	assign o_vram_pb_rw = 1'b0;
	assign o_vram_pb_wdata = '0;

	assign fetch_address = vram_offset + addr_t'(i_video_pos_y) * `VMODE_PITCH
		+ addr_t'({i_video_pos_x[8:2], 2'b00});

	assign fetch_start = (fetch_state == FETCH_IDLE) && i_video_request
		&& (i_video_pos_x[1:0] == 2'd0);
	assign pixel_hit = (fetch_state == FETCH_IDLE) && i_video_request
		&& (i_video_pos_x[1:0] != 2'd0);
	assign word_taken = (fetch_state == FETCH_WAIT) && i_vram_pb_ready;
	assign look_store = (fetch_state == FETCH_LOOK) && (look_cnt != 3'd0);

	// lowest byte first; the palette answers one cycle later.
	assign pal_rd_index = quad_word[8*look_cnt[1:0] +: 8];

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			fetch_state <= FETCH_IDLE;
			look_cnt <= '0;
			o_vram_pb_request <= 1'b0;
			o_video_valid <= 1'b0;
		end else begin
			o_video_valid <= 1'b0;
			case (fetch_state)
				FETCH_IDLE: begin
					if (fetch_start) begin
						o_vram_pb_request <= 1'b1;
						fetch_state <= FETCH_WAIT;
					end else if (pixel_hit) begin
						o_video_valid <= 1'b1;
					end
				end
				FETCH_WAIT: begin
					if (i_vram_pb_ready) begin
						o_vram_pb_request <= 1'b0;
						look_cnt <= '0;
						fetch_state <= FETCH_LOOK;
					end
				end
				FETCH_LOOK: begin
					look_cnt <= look_cnt + 3'd1;
					if (look_cnt == 3'd4)
						fetch_state <= FETCH_SEND;
				end
				FETCH_SEND: begin
					o_video_valid <= 1'b1;
					fetch_state <= FETCH_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (fetch_start)
			o_vram_pb_address <= fetch_address;
		if (word_taken)
			quad_word <= i_vram_pb_rdata;
		if (look_store)
			colour[look_cnt[1:0] - 2'd1] <= pal_rd_rgb;
		if (pixel_hit)
			o_video_rgb <= colour[i_video_pos_x[1:0]];
		else if (fetch_state == FETCH_SEND)
			o_video_rgb <= colour[0];
	end

	a_one_pixel_outstanding: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_video_request |-> (fetch_state == FETCH_IDLE));

endmodule

`default_nettype wire

// ==== source/vmode_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module vmode_top (
	input  wire                    i_clock,
	input  wire                    i_rst_n,

	input  wire                    i_cpu_request,
	input  wire                    i_cpu_rw,
	input  wire vmode_pkg::addr_t  i_cpu_address,
	input  wire vmode_pkg::word_t  i_cpu_wdata,
	output vmode_pkg::word_t       o_cpu_rdata,
	output logic                   o_cpu_ready,

	input  wire                    i_video_request,
	input  wire vmode_pkg::coord_t i_video_pos_x,
	input  wire vmode_pkg::coord_t i_video_pos_y,
	output vmode_pkg::rgb_t        o_video_rgb,
	output logic                   o_video_valid
);

	import vmode_pkg::*;

	// port a, cpu traffic.
	logic pa_request;
	logic pa_rw;
	addr_t pa_address;
	word_t pa_wdata;
	word_t pa_rdata;
	logic pa_ready;

	// port b, video traffic.
	logic pb_request;
	logic pb_rw;
	addr_t pb_address;
	word_t pb_wdata;
	word_t pb_rdata;
	logic pb_ready;

	chunky_mode u_chunky (
		.i_clock           (i_clock),
		.i_rst_n           (i_rst_n),
		.i_cpu_request     (i_cpu_request),
		.i_cpu_rw          (i_cpu_rw),
		.i_cpu_address     (i_cpu_address),
		.i_cpu_wdata       (i_cpu_wdata),
		.o_cpu_rdata       (o_cpu_rdata),
		.o_cpu_ready       (o_cpu_ready),
		.i_video_request   (i_video_request),
		.i_video_pos_x     (i_video_pos_x),
		.i_video_pos_y     (i_video_pos_y),
		.o_video_rgb       (o_video_rgb),
		.o_video_valid     (o_video_valid),
		.o_vram_pa_request (pa_request),
		.o_vram_pa_rw      (pa_rw),
		.o_vram_pa_address (pa_address),
		.o_vram_pa_wdata   (pa_wdata),
		.i_vram_pa_rdata   (pa_rdata),
		.i_vram_pa_ready   (pa_ready),
		.o_vram_pb_request (pb_request),
		.o_vram_pb_rw      (pb_rw),
		.o_vram_pb_address (pb_address),
		.o_vram_pb_wdata   (pb_wdata),
		.i_vram_pb_rdata   (pb_rdata),
		.i_vram_pb_ready   (pb_ready)
	);

	vram_dual u_vram (
		.i_clock      (i_clock),
		.i_rst_n      (i_rst_n),
		.i_pa_request (pa_request),
		.i_pa_rw      (pa_rw),
		.i_pa_address (pa_address),
		.i_pa_wdata   (pa_wdata),
		.o_pa_rdata   (pa_rdata),
		.o_pa_ready   (pa_ready),
		.i_pb_request (pb_request),
		.i_pb_rw      (pb_rw),
		.i_pb_address (pb_address),
		.i_pb_wdata   (pb_wdata),
		.o_pb_rdata   (pb_rdata),
		.o_pb_ready   (pb_ready)
	);

endmodule

`default_nettype wire

// ==== bench/tb_vmode_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vmode_consts.svh"

module tb_vmode_top;

	import vmode_pkg::*;

	logic i_clock = 1'b0;
	logic i_rst_n;
	logic i_cpu_request;
	logic i_cpu_rw;
	addr_t i_cpu_address;
	word_t i_cpu_wdata;
	word_t o_cpu_rdata;
	logic o_cpu_ready;
	logic i_video_request;
	coord_t i_video_pos_x;
	coord_t i_video_pos_y;
	rgb_t o_video_rgb;
	logic o_video_valid;

	integer seed = 17;
	int mismatches = 0;
	int failures = 0;

	// reference state.
	logic [31:0] vram_model [`VMODE_VRAM_WORDS];
	logic [23:0] pal_model [`VMODE_PAL_SIZE];
	logic [31:0] cpu_off_model;
	logic [31:0] vram_off_model;
	logic [31:0] addr_q [$];

	vmode_top dut (
		.i_clock         (i_clock),
		.i_rst_n         (i_rst_n),
		.i_cpu_request   (i_cpu_request),
		.i_cpu_rw        (i_cpu_rw),
		.i_cpu_address   (i_cpu_address),
		.i_cpu_wdata     (i_cpu_wdata),
		.o_cpu_rdata     (o_cpu_rdata),
		.o_cpu_ready     (o_cpu_ready),
		.i_video_request (i_video_request),
		.i_video_pos_x   (i_video_pos_x),
		.i_video_pos_y   (i_video_pos_y),
		.o_video_rgb     (o_video_rgb),
		.o_video_valid   (o_video_valid)
	);

	always #20 i_clock = ~i_clock;

	// ==================================================
	// model helpers.
	// ==================================================

	function automatic logic [12:0] vram_index(input logic [31:0] byte_addr);
		logic [31:0] w;
		w = (byte_addr >> 2) % `VMODE_VRAM_WORDS;
		return w[12:0];
	endfunction

	// colour of pixel x on line y, from the quad at the group start.
	function automatic logic [23:0] pixel_colour(input int xi, input int yi);
		logic [31:0] byte_addr;
		logic [31:0] quad;
		logic [31:0] shifted;
		byte_addr = vram_off_model + yi * `VMODE_PITCH + xi - (xi % 4);
		quad = vram_model[vram_index(byte_addr)];
		shifted = quad >> (8 * (xi % 4));
		return pal_model[shifted[7:0]];
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
			mismatches++;
		end
	endtask

	// ==================================================
	// bus drivers.
	// ==================================================

	task automatic access_cpu(input logic rw, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		logic seen;
		seen = 1'b0;
		rdata = '0;
		@(posedge i_clock);
		i_cpu_request <= 1'b1;
		i_cpu_rw <= rw;
		i_cpu_address <= addr;
		i_cpu_wdata <= wdata;
		for (int n = 0; n < 50 && !seen; n++) begin
			@(negedge i_clock);
			if (o_cpu_ready) begin
				seen = 1'b1;
				rdata = o_cpu_rdata;
			end
		end
		assert (seen) else begin
			$display("Timeout: no o_cpu_ready within 50 cycles for address %h", addr);
			failures++;
		end
		@(posedge i_clock);
		i_cpu_request <= 1'b0;
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		logic [31:0] pal_pos;
		access_cpu(1'b1, addr, data, unused);
		if (addr < `VMODE_PAL_BASE) begin
			vram_model[vram_index(cpu_off_model + addr)] = data;
		end else if (addr < `VMODE_REG_BASE) begin
			pal_pos = (addr - `VMODE_PAL_BASE) >> 2;
			pal_model[pal_pos[7:0]] = data[23:0];
		end else if (addr - `VMODE_REG_BASE == `VMODE_REG_VRAM_OFS) begin
			vram_off_model = data;
		end else if (addr - `VMODE_REG_BASE == `VMODE_REG_CPU_OFS) begin
			cpu_off_model = data;
		end
	endtask

	task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
		access_cpu(1'b0, addr, '0, data);
	endtask

	task automatic request_pixel(input int xi, input int yi, output logic [23:0] rgb);
		logic seen;
		seen = 1'b0;
		rgb = '0;
		@(posedge i_clock);
		i_video_request <= 1'b1;
		i_video_pos_x <= xi[8:0];
		i_video_pos_y <= yi[8:0];
		@(posedge i_clock);
		i_video_request <= 1'b0;
		for (int n = 0; n < 50 && !seen; n++) begin
			@(negedge i_clock);
			if (o_video_valid) begin
				seen = 1'b1;
				rgb = o_video_rgb;
			end
		end
		assert (seen) else begin
			$display("Timeout: no o_video_valid within 50 cycles for pixel %0d,%0d", xi, yi);
			failures++;
		end
	endtask

	task automatic check_line(input int yi, input int width);
		logic [23:0] got;
		for (int xi = 0; xi < width; xi++) begin
			request_pixel(xi, yi, got);
			compare_value("o_video_rgb", {8'h00, pixel_colour(xi, yi)}, {8'h00, got});
		end
	endtask

	// ==================================================
	// test sequence.
	// ==================================================

	initial begin
		logic [31:0] r;
		logic [31:0] got;
		logic [31:0] off;
		i_rst_n <= 1'b0;
		i_cpu_request <= 1'b0;
		i_cpu_rw <= 1'b0;
		i_cpu_address <= '0;
		i_cpu_wdata <= '0;
		i_video_request <= 1'b0;
		i_video_pos_x <= '0;
		i_video_pos_y <= '0;
		cpu_off_model = '0;
		vram_off_model = '0;

		// outputs stay quiet in reset and just after it.
		for (int c = 0; c < 3; c++) begin
			@(negedge i_clock);
			assert (o_cpu_ready === 1'b0 && o_video_valid === 1'b0) else begin
				$display("o_cpu_ready or o_video_valid is not low around reset at %0t", $time);
				failures++;
			end
			if (c == 1) begin
				@(posedge i_clock);
				i_rst_n <= 1'b1;
			end
		end

		// vram round trip.
		for (int i = 0; i < 32; i++) begin
			r = $random(seed);
			addr_q.push_back(r & 32'h007F_FFFC);
			write_word(r & 32'h007F_FFFC, $random(seed));
		end
		foreach (addr_q[i]) begin
			read_word(addr_q[i], got);
			compare_value("o_cpu_rdata", vram_model[vram_index(addr_q[i])], got);
		end

		// writes through a cpu offset, read back at the translated address.
		r = $random(seed);
		off = r & 32'h0003_FFFC;
		write_word(`VMODE_REG_BASE + `VMODE_REG_CPU_OFS, off);
		addr_q.delete();
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			addr_q.push_back(r & 32'h0000_FFFC);
			write_word(r & 32'h0000_FFFC, $random(seed));
		end
		write_word(`VMODE_REG_BASE + `VMODE_REG_CPU_OFS, 32'h0);
		foreach (addr_q[i]) begin
			read_word(off + addr_q[i], got);
			compare_value("o_cpu_rdata", vram_model[vram_index(off + addr_q[i])], got);
		end

		// palette and register regions read as zero.
		write_word(`VMODE_PAL_BASE + 32'h10, $random(seed));
		read_word(`VMODE_PAL_BASE + 32'h10, got);
		compare_value("o_cpu_rdata", 32'h0, got);
		read_word(`VMODE_REG_BASE + `VMODE_REG_CPU_OFS, got);
		compare_value("o_cpu_rdata", 32'h0, got);

		// random palette and a full vram image.
		for (int i = 0; i < `VMODE_PAL_SIZE; i++)
			write_word(`VMODE_PAL_BASE + i * 4, $random(seed));
		for (int i = 0; i < `VMODE_VRAM_WORDS; i++)
			write_word(i * 4, $random(seed));

		for (int l = 0; l < 4; l++) begin
			r = $random(seed);
			check_line(r[7:0] % 240, 40);
		end

		// shifted video base.
		r = $random(seed);
		write_word(`VMODE_REG_BASE + `VMODE_REG_VRAM_OFS, r & 32'h0000_FFFC);
		r = $random(seed);
		check_line(r[7:0] % 240, 40);

		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+source
source/vmode_pkg.sv
source/palette_ram.sv
source/vram_dual.sv
source/chunky_mode.sv
source/vmode_top.sv
bench/tb_vmode_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps --top-module tb_vmode_top \
	-f sim.f -o tb_vmode_top

output="$(./obj_dir/tb_vmode_top)"
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
exit 1
